//--- hw/busPkg.sv
package busPkg;

    typedef logic [31:0] cpuWord;
    typedef logic [31:0] cpuAddress;

    // Command byte in the top of a data address
    typedef enum logic [7:0] {
        none          = 8'd0,
        writeLeds1    = 8'd1,
        writeLeds2    = 8'd2,
        writeLeds3    = 8'd3,
        writeLeds4    = 8'd4,
        writeFrame0   = 8'd5,
        writeFrame1   = 8'd6,
        toggleDisplay = 8'd7,
        loadButtons   = 8'd8
    } specialCommand;

    // Address fields, all one byte wide
    localparam int fieldBits  = 8;
    localparam int commandLsb = 24;
    localparam int yLsb       = 8;
    localparam int xLsb       = 0;

    // Shown on the LEDs until the program image is loaded
    localparam logic [7:0] ledPattern = 8'b10101010;

    localparam int buttonCount = 7;

endpackage

//--- hw/videoPkg.sv
package videoPkg;

    // One byte of colour per pixel
    typedef logic [7:0] pixel;

    typedef logic [7:0] coordinate;

endpackage

//--- hw/syncMemory.sv
module syncMemory #(
    parameter int  entries   = 1024,
    parameter type entryType = logic [31:0]
) (
    input  logic                       CPUClock,
    input  logic                       reset,
    input  logic                       read,
    input  logic                       write,
    input  logic [$clog2(entries)-1:0] address,
    input  entryType                   writeData,
    output entryType                   readData,
    output logic                       done
);

    entryType storage [entries];

    // Registered read, readData holds until the next read
    always_ff @(posedge CPUClock) begin
        if (write) begin
            storage[address] <= writeData;
        end
        if (read) begin
            readData <= storage[address];
        end
    end

    always_ff @(posedge CPUClock) begin
        if (reset) begin
            done <= 1'b0;
        end else begin
            done <= read || write;
        end
    end

    // Single port, one access per cycle
    assert property (@(posedge CPUClock) disable iff (reset) !(read && write));

endmodule

//--- hw/bootLoader.sv
module bootLoader
    import busPkg::*;
#(
    parameter int gapCycles = 4
) (
    input  logic      CPUClock,
    input  logic      reset,
    input  logic      sdBusy,
    input  cpuWord    sdData,
    output logic      sdRead,
    output cpuAddress sdAddress,
    output logic      loadWrite,
    output cpuAddress loadAddress,
    output cpuWord    loadData,
    output logic      booted
);

    localparam int gapBits = $clog2(gapCycles + 2);

    typedef enum logic [2:0] {
        fetchLength,
        waitLength,
        fetchWord,
        waitWord,
        done
    } loaderState;

    loaderState         state;
    logic [gapBits-1:0] gapCount;
    cpuWord             remaining;
    logic               wordReady;

    // Busy rises the cycle after the request, so skip the request cycle itself
    assign wordReady = !sdRead && !sdBusy;

    //////////////////////////////
    // Loader FSM
    //////////////////////////////
    always_ff @(posedge CPUClock) begin
        if (reset) begin
            state     <= fetchLength;
            gapCount  <= '0;
            remaining <= '0;
            sdRead    <= 1'b0;
            sdAddress <= '0;
            loadWrite <= 1'b0;
            booted    <= 1'b0;
        end else begin
            sdRead    <= 1'b0;
            loadWrite <= 1'b0;
            case (state)
                fetchLength, fetchWord: begin
                    if (gapCount != '0) begin
                        gapCount <= gapCount - 1'b1;
                    end else begin
                        sdRead <= 1'b1;
                        state  <= (state == fetchLength) ? waitLength : waitWord;
                    end
                end
                waitLength: begin
                    if (wordReady) begin
                        gapCount  <= gapBits'(gapCycles);
                        remaining <= sdData;
                        sdAddress <= cpuAddress'(1);
                        // Empty image, nothing to copy
                        state     <= (sdData == '0) ? done : fetchWord;
                    end
                end
                waitWord: begin
                    if (wordReady) begin
                        gapCount  <= gapBits'(gapCycles);
                        sdAddress <= sdAddress + 1'b1;
                        remaining <= remaining - 1'b1;
                        loadWrite <= 1'b1;
                        state     <= (remaining == cpuWord'(1)) ? done : fetchWord;
                    end
                end
                done: begin
                    // Last RAM write is under way in this cycle
                    booted <= 1'b1;
                end
                default: begin
                    state <= fetchLength;
                end
            endcase
        end
    end

    // SD word 1 lands in RAM word 0
    always_ff @(posedge CPUClock) begin
        if (state == waitWord && wordReady) begin
            loadAddress <= sdAddress - 1'b1;
            loadData    <= sdData;
        end
    end

    assert property (@(posedge CPUClock) disable iff (reset) booted |-> !loadWrite);

endmodule

//--- hw/busRouter.sv
module busRouter
    import busPkg::*;
(
    input  logic              CPUClock,
    input  logic              reset,
    input  logic              booted,
    input  logic              cpuRead,
    input  logic              cpuWrite,
    input  busPkg::cpuAddress cpuAddress,
    input  cpuWord            cpuWriteData,
    output cpuWord            cpuReadData,
    output logic              cpuDone,
    input  logic              loadWrite,
    input  busPkg::cpuAddress loadAddress,
    input  cpuWord            loadData,
    output logic              memRead,
    output logic              memWrite,
    output busPkg::cpuAddress memAddress,
    output cpuWord            memWriteData,
    input  cpuWord            memReadData,
    input  logic              memDone,
    output logic              specialWrite,
    output logic              specialRead,
    input  cpuWord            ioReadData
);

    specialCommand command;
    logic          accept;
    logic          ramRead;
    logic          ramWrite;
    logic          ramPending;
    logic          specialDone;

    assign command = specialCommand'(cpuAddress[commandLsb +: fieldBits]);

    // Nothing is served before boot, and a request is dropped while its done is up
    assign accept       = booted && !cpuDone;
    assign ramRead      = accept && cpuRead && (command == none);
    assign ramWrite     = accept && cpuWrite && (command == none);
    assign specialRead  = accept && cpuRead && (command != none);
    assign specialWrite = accept && cpuWrite && (command != none);

    // RAM belongs to the loader until boot ends
    always_comb begin
        if (!booted) begin
            memRead      = 1'b0;
            memWrite     = loadWrite;
            memAddress   = loadAddress;
            memWriteData = loadData;
        end else begin
            memRead      = ramRead;
            memWrite     = ramWrite;
            memAddress   = cpuAddress;
            memWriteData = cpuWriteData;
        end
    end

    always_ff @(posedge CPUClock) begin
        if (reset) begin
            ramPending  <= 1'b0;
            specialDone <= 1'b0;
        end else begin
            ramPending  <= ramRead || ramWrite;
            specialDone <= specialRead || specialWrite;
        end
    end

    // Loader writes also raise memDone, hence the pending flag
    assign cpuDone     = (ramPending && memDone) || specialDone;
    assign cpuReadData = specialDone ? ioReadData : memReadData;

    assert property (@(posedge CPUClock) disable iff (reset) !(cpuRead && cpuWrite));

endmodule

//--- hw/ioRegisters.sv
module ioRegisters
    import busPkg::*, videoPkg::*;
(
    input  logic                   CPUClock,
    input  logic                   reset,
    input  logic                   booted,
    input  logic                   specialWrite,
    input  logic                   specialRead,
    input  busPkg::cpuAddress      cpuAddress,
    input  cpuWord                 cpuWriteData,
    input  logic [buttonCount-1:0] buttons,
    output cpuWord                 ioReadData,
    output logic [7:0]             leds,
    output logic                   displaySelect,
    output logic                   frameWrite0,
    output logic                   frameWrite1,
    output coordinate              frameX,
    output coordinate              frameY,
    output pixel                   frameColor
);

    specialCommand command;
    logic [7:0]    ledReg;

    assign command = specialCommand'(cpuAddress[commandLsb +: fieldBits]);

    //////////////////////////////
    // Command registers
    //////////////////////////////
    always_ff @(posedge CPUClock) begin
        if (reset) begin
            ledReg        <= ledPattern;
            displaySelect <= 1'b0;
            frameWrite0   <= 1'b0;
            frameWrite1   <= 1'b0;
        end else begin
            frameWrite0 <= specialWrite && (command == writeFrame0);
            frameWrite1 <= specialWrite && (command == writeFrame1);
            if (specialWrite) begin
                case (command)
                    writeLeds1:    ledReg <= cpuWriteData[7:0];
                    writeLeds2:    ledReg <= cpuWriteData[15:8];
                    writeLeds3:    ledReg <= cpuWriteData[23:16];
                    writeLeds4:    ledReg <= cpuWriteData[31:24];
                    toggleDisplay: displaySelect <= !displaySelect;
                    default:       ;
                endcase
            end
        end
    end

    // Pixel payload, taken with every special write
    always_ff @(posedge CPUClock) begin
        if (specialWrite) begin
            frameX     <= cpuAddress[xLsb +: fieldBits];
            frameY     <= cpuAddress[yLsb +: fieldBits];
            frameColor <= cpuWriteData[7:0];
        end
    end

    // Button 0 is left out of the answer
    always_ff @(posedge CPUClock) begin
        if (specialRead) begin
            if (command == loadButtons) begin
                ioReadData <= cpuWord'(buttons[buttonCount-1:1]);
            end else begin
                ioReadData <= '0;
            end
        end
    end

    assign leds = booted ? ledReg : ledPattern;

endmodule

//--- hw/buttonCapture.sv
module buttonCapture
    import busPkg::*;
#(
    parameter int holdCycles = 16
) (
    input  logic                   CPUClock,
    input  logic                   reset,
    input  logic [buttonCount-1:0] buttonsIn,
    output logic [buttonCount-1:0] buttons
);

    localparam int timerBits = $clog2(holdCycles + 1);

    logic [timerBits-1:0] holdTimer [buttonCount];

    always_ff @(posedge CPUClock) begin
        for (int i = 0; i < buttonCount; i++) begin
            if (reset) begin
                holdTimer[i] <= '0;
                buttons[i]   <= 1'b0;
            end else if (holdTimer[i] == '0) begin
                // Idle timer, a press starts a new hold
                if (buttonsIn[i]) begin
                    buttons[i]   <= 1'b1;
                    holdTimer[i] <= timerBits'(holdCycles);
                end
            end else begin
                holdTimer[i] <= holdTimer[i] - 1'b1;
                if (holdTimer[i] == timerBits'(1)) begin
                    buttons[i] <= 1'b0;
                end
            end
        end
    end

endmodule

//--- hw/frameBufferPair.sv
module frameBufferPair
    import videoPkg::*;
#(
    parameter int frameWidth  = 64,
    parameter int frameHeight = 64
) (
    input  logic      CPUClock,
    input  logic      reset,
    input  logic      frameWrite0,
    input  logic      frameWrite1,
    input  coordinate frameX,
    input  coordinate frameY,
    input  pixel      frameColor,
    input  logic      displaySelect,
    input  coordinate videoX,
    input  coordinate videoY,
    output pixel      videoPixel
);

    localparam int frameEntries = frameWidth * frameHeight;
    localparam int indexBits    = $clog2(frameEntries);

    logic [indexBits-1:0] writeIndex;
    logic [indexBits-1:0] videoIndex;
    logic [1:0]           writeStrobe;
    pixel                 bufferPixel [2];
    logic                 shownBuffer;

    // Row major layout
    assign writeIndex  = indexBits'(frameY * frameWidth + frameX);
    assign videoIndex  = indexBits'(videoY * frameWidth + videoX);
    assign writeStrobe = {frameWrite1, frameWrite0};

    for (genvar bufferIndex = 0; bufferIndex < 2; bufferIndex++) begin : buffer
        logic [indexBits-1:0] index;

        // A pixel write takes the port for one cycle, video read skips it
        assign index = writeStrobe[bufferIndex] ? writeIndex : videoIndex;

        syncMemory #(
            .entries  (frameEntries),
            .entryType(pixel)
        ) memory (
            .CPUClock (CPUClock),
            .reset    (reset),
            .read     (!writeStrobe[bufferIndex]),
            .write    (writeStrobe[bufferIndex]),
            .address  (index),
            .writeData(frameColor),
            .readData (bufferPixel[bufferIndex]),
            .done     ()
        );
    end

    // Select travels with the read, one cycle behind the coordinate
    always_ff @(posedge CPUClock) begin
        if (reset) begin
            shownBuffer <= 1'b0;
        end else begin
            shownBuffer <= displaySelect;
        end
    end

    assign videoPixel = bufferPixel[shownBuffer];

    assert property (@(posedge CPUClock) disable iff (reset)
        (frameWrite0 || frameWrite1) |-> (frameX < frameWidth && frameY < frameHeight));

endmodule

//--- hw/gameSystem.sv
module gameSystem
    import busPkg::*, videoPkg::*;
#(
    parameter int ramWords    = 32768,
    parameter int frameWidth  = 64,
    parameter int frameHeight = 64,
    parameter int gapCycles   = 4,
    parameter int holdCycles  = 16
) (
    input  logic                   CPUClock,
    input  logic                   reset,
    input  logic                   cpuRead,
    input  logic                   cpuWrite,
    input  busPkg::cpuAddress      cpuAddress,
    input  cpuWord                 cpuWriteData,
    output cpuWord                 cpuReadData,
    output logic                   cpuDone,
    output logic                   sdRead,
    output busPkg::cpuAddress      sdAddress,
    input  logic                   sdBusy,
    input  cpuWord                 sdData,
    input  logic [buttonCount-1:0] buttonsIn,
    output logic [7:0]             leds,
    output logic                   booted,
    input  coordinate              videoX,
    input  coordinate              videoY,
    output pixel                   videoPixel
);

    localparam int ramBits = $clog2(ramWords);

    // Loader to router
    logic              loadWrite;
    busPkg::cpuAddress loadAddress;
    cpuWord            loadData;

    // Router to main RAM
    logic              memRead;
    logic              memWrite;
    busPkg::cpuAddress memAddress;
    cpuWord            memWriteData;
    cpuWord            memReadData;
    logic              memDone;

    // Special commands and peripherals
    logic                   specialWrite;
    logic                   specialRead;
    cpuWord                 ioReadData;
    logic [buttonCount-1:0] buttons;
    logic                   displaySelect;
    logic                   frameWrite0;
    logic                   frameWrite1;
    coordinate              frameX;
    coordinate              frameY;
    pixel                   frameColor;

    bootLoader #(.gapCycles(gapCycles)) bootLoader_i (.*);

    busRouter busRouter_i (.*);

    syncMemory #(
        .entries  (ramWords),
        .entryType(cpuWord)
    ) ramMemory (
        .CPUClock (CPUClock),
        .reset    (reset),
        .read     (memRead),
        .write    (memWrite),
        .address  (memAddress[ramBits-1:0]),
        .writeData(memWriteData),
        .readData (memReadData),
        .done     (memDone)
    );

    ioRegisters ioRegisters_i (.*);

    buttonCapture #(.holdCycles(holdCycles)) buttonCapture_i (.*);

    frameBufferPair #(
        .frameWidth (frameWidth),
        .frameHeight(frameHeight)
    ) frameBufferPair_i (.*);

endmodule

//--- dv/sdCardModel.sv
module sdCardModel
    import busPkg::*;
#(
    parameter int imageWords = 12,
    parameter int maxBusy    = 8
) (
    input  logic      CPUClock,
    input  logic      reset,
    input  logic      sdRead,
    input  cpuAddress sdAddress,
    output logic      sdBusy,
    output cpuWord    sdData
);

    // Word 0 is the length, the rest is the program
    cpuWord image [imageWords];
    integer seed;
    int     busyLeft;
    cpuWord word;

    initial begin
        seed = 19825;
        image[0] = cpuWord'(imageWords - 1);
        for (int k = 1; k < imageWords; k++) begin
            image[k] = $random(seed);
        end
        busyLeft = 0;
        word     = '0;
        sdBusy   = 1'b0;
        sdData   = '0;

        //////////////////////////////
        // Request service
        //////////////////////////////
        forever begin
            @(posedge CPUClock);
            if (reset) begin
                busyLeft = 0;
            end else if (sdRead) begin
                // Card latency differs from one request to the next
                busyLeft = 1 + int'($unsigned($random(seed)) % maxBusy);
                if (sdAddress < imageWords) begin
                    word = image[int'(sdAddress)];
                end else begin
                    word = '0;
                end
            end else if (busyLeft != 0) begin
                busyLeft = busyLeft - 1;
            end
            #1;
            sdBusy = (busyLeft != 0);
            if (busyLeft == 0) begin
                sdData = word;
            end
        end
    end

endmodule

//--- dv/gameSystemTb.sv
module gameSystemTb
    import busPkg::*, videoPkg::*;
;

    localparam int ramWords    = 1024;
    localparam int gapCycles   = 4;
    localparam int holdCycles  = 16;
    localparam int imageWords  = 12;
    localparam int maxBusy     = 8;
    localparam int resetCycles = 5;
    localparam int bootBound   = imageWords * (maxBusy + gapCycles + 4);

    typedef enum logic [2:0] {
        opWrite,
        opWriteLeds,
        opRead,
        opVideo,
        opPress,
        opWait
    } stepKind;

    typedef struct packed {
        stepKind           kind;
        busPkg::cpuAddress address;
        cpuWord            data;
        cpuWord            expected;
    } stimulusStep;

    logic                   CPUClock;
    logic                   reset;
    logic                   cpuRead;
    logic                   cpuWrite;
    busPkg::cpuAddress      cpuAddress;
    cpuWord                 cpuWriteData;
    cpuWord                 cpuReadData;
    logic                   cpuDone;
    logic                   sdRead;
    busPkg::cpuAddress      sdAddress;
    logic                   sdBusy;
    cpuWord                 sdData;
    logic [buttonCount-1:0] buttonsIn;
    logic [7:0]             leds;
    logic                   booted;
    coordinate              videoX;
    coordinate              videoY;
    pixel                   videoPixel;

    stimulusStep steps [$];
    int          cycleCount    = 0;
    int          cycleLimit    = 0;
    int          lastDoneCycle = -1;

    gameSystem #(
        .ramWords  (ramWords),
        .gapCycles (gapCycles),
        .holdCycles(holdCycles)
    ) gameSystem_i (.*);

    sdCardModel #(
        .imageWords(imageWords),
        .maxBusy   (maxBusy)
    ) sdCard (.*);

    initial begin
        CPUClock = 1'b0;
        forever #4 CPUClock = ~CPUClock;
    end

    always @(posedge CPUClock) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            $display("Timeout: the run hung and was stopped after %0d cycles", cycleCount);
            failRun();
        end
    end

    //////////////////////////////
    // Checks
    //////////////////////////////
    task automatic failRun();
        $display("*** TEST FAILED ***");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic checkWord(input string name, input cpuWord actual, input cpuWord expected);
        if (actual !== expected) begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, actual, expected);
            failRun();
        end
    endtask

    task automatic checkLeds(input string name, input logic [7:0] actual,
                             input logic [7:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, actual, expected);
            failRun();
        end
    endtask

    task automatic checkPixel(input string name, input pixel actual, input pixel expected);
        if (actual !== expected) begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, actual, expected);
            failRun();
        end
    endtask

    //////////////////////////////
    // Bus helpers
    //////////////////////////////
    task automatic waitCycle();
        @(posedge CPUClock);
        #1;
    endtask

    // Request is held until done shows up and then dropped
    task automatic cpuAccess(input logic isWrite, input busPkg::cpuAddress address,
                             input cpuWord data, output cpuWord readValue);
        int waited;
        int expectedWait;
        waited = 0;
        // A request that meets the previous done pulse is served one cycle later
        expectedWait = (cycleCount == lastDoneCycle) ? 2 : 1;
        cpuRead      = !isWrite;
        cpuWrite     = isWrite;
        cpuAddress   = address;
        cpuWriteData = data;
        waitCycle();
        waited++;
        while (!cpuDone) begin
            waitCycle();
            waited++;
        end
        if (waited != expectedWait) begin
            $display("cpuDone came %0d cycles after the request instead of %0d",
                     waited, expectedWait);
            failRun();
        end
        readValue     = cpuReadData;
        cpuRead       = 1'b0;
        cpuWrite      = 1'b0;
        lastDoneCycle = cycleCount;
    endtask

    task automatic waitForBoot();
        int reads;
        reads = 0;
        while (!booted) begin
            checkLeds("leds", leds, ledPattern);
            if (sdRead) begin
                reads++;
            end
            waitCycle();
        end
        if (reads != imageWords) begin
            $display("Boot ended after %0d SD reads instead of %0d", reads, imageWords);
            failRun();
        end
    endtask

    // RAM word k holds SD word k+1
    task automatic checkBootImage();
        cpuWord value;
        for (int k = 0; k < imageWords - 1; k++) begin
            cpuAccess(1'b0, busPkg::cpuAddress'(k), '0, value);
            checkWord("cpuReadData", value, sdCard.image[k + 1]);
        end
    endtask

    task automatic addStep(input stepKind kind, input busPkg::cpuAddress address,
                           input cpuWord data, input cpuWord expected);
        stimulusStep step;
        step.kind     = kind;
        step.address  = address;
        step.data     = data;
        step.expected = expected;
        steps.push_back(step);
    endtask

    task automatic buildTable();
        // One LED byte lane per command
        addStep(opWriteLeds, 32'h0100_0000, 32'hC3A5_5A3C, 32'h3C);
        addStep(opWriteLeds, 32'h0200_0000, 32'hC3A5_5A3C, 32'h5A);
        addStep(opWriteLeds, 32'h0300_0000, 32'hC3A5_5A3C, 32'hA5);
        addStep(opWriteLeds, 32'h0400_0000, 32'hC3A5_5A3C, 32'hC3);
        // RAM round trip and a command aimed at the same low address
        addStep(opWrite,     32'h0000_0005, 32'h1234_5678, 32'h0);
        addStep(opRead,      32'h0000_0005, 32'h0,         32'h1234_5678);
        addStep(opWriteLeds, 32'h0100_0005, 32'h0000_0099, 32'h99);
        addStep(opRead,      32'h0000_0005, 32'h0,         32'h1234_5678);
        addStep(opWrite,     32'h0000_012C, 32'hDEAD_BEEF, 32'h0);
        addStep(opRead,      32'h0000_012C, 32'h0,         32'hDEAD_BEEF);
        // Same pixel in a different colour per buffer
        addStep(opWrite,     32'h0500_140A, 32'h0000_003C, 32'h0);
        addStep(opWrite,     32'h0600_140A, 32'h0000_00E1, 32'h0);
        addStep(opVideo,     32'h0000_140A, 32'h0,         32'h3C);
        addStep(opWrite,     32'h0700_0000, 32'h0,         32'h0);
        addStep(opVideo,     32'h0000_140A, 32'h0,         32'hE1);
        addStep(opWrite,     32'h0700_0000, 32'h0,         32'h0);
        addStep(opVideo,     32'h0000_140A, 32'h0,         32'h3C);
        // Buttons 1 and 3 come back as bits 0 and 2 while the hold lasts
        addStep(opPress,     32'h0,         32'h0A,         32'h0);
        addStep(opWait,      32'h0,         holdCycles / 2, 32'h0);
        addStep(opRead,      32'h0800_0000, 32'h0,          32'h5);
        addStep(opWait,      32'h0,         holdCycles + 2, 32'h0);
        addStep(opRead,      32'h0800_0000, 32'h0,          32'h0);
    endtask

    task automatic applyStep(input stimulusStep step);
        cpuWord readValue;
        case (step.kind)
            opWrite: begin
                cpuAccess(1'b1, step.address, step.data, readValue);
            end
            opWriteLeds: begin
                cpuAccess(1'b1, step.address, step.data, readValue);
                checkLeds("leds", leds, step.expected[7:0]);
            end
            opRead: begin
                cpuAccess(1'b0, step.address, '0, readValue);
                checkWord("cpuReadData", readValue, step.expected);
            end
            opVideo: begin
                videoX = step.address[7:0];
                videoY = step.address[15:8];
                waitCycle();
                checkPixel("videoPixel", videoPixel, pixel'(step.expected));
            end
            opPress: begin
                buttonsIn = step.data[buttonCount-1:0];
                waitCycle();
                buttonsIn = '0;
            end
            default: begin
                repeat (step.data) waitCycle();
            end
        endcase
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////
    initial begin
        reset        = 1'b1;
        cpuRead      = 1'b0;
        cpuWrite     = 1'b0;
        cpuAddress   = '0;
        cpuWriteData = '0;
        buttonsIn    = '0;
        videoX       = '0;
        videoY       = '0;
        buildTable();
        cycleLimit = 2 * (2 * bootBound + 2 * resetCycles
                          + 20 * (steps.size() + 2 * imageWords));

        repeat (resetCycles) waitCycle();
        reset = 1'b0;
        waitForBoot();
        checkBootImage();

        foreach (steps[i]) begin
            applyStep(steps[i]);
        end

        // Second boot restores the image over the test writes
        reset = 1'b1;
        repeat (resetCycles) waitCycle();
        checkLeds("leds", leds, ledPattern);
        if (booted !== 1'b0) begin
            $display("booted stayed high while reset was asserted");
            failRun();
        end
        reset = 1'b0;
        waitForBoot();
        checkBootImage();

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

//--- gameSystem.f
hw/busPkg.sv
hw/videoPkg.sv
hw/syncMemory.sv
hw/bootLoader.sv
hw/busRouter.sv
hw/ioRegisters.sv
hw/buttonCapture.sv
hw/frameBufferPair.sv
hw/gameSystem.sv
dv/sdCardModel.sv
dv/gameSystemTb.sv

//--- runSim.sh
#!/bin/sh
# Compile and run the gameSystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

logFile=sim.log

verilator --binary --timing --assert -Wno-fatal -f gameSystem.f \
    --top-module gameSystemTb -Mdir obj_dir -o simGameSystem
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/simGameSystem > "$logFile" 2>&1
runStatus=$?
cat "$logFile"

if grep -q "TEST FAILED" "$logFile"; then
    echo "Simulation reported a failure, see $logFile"
    exit 1
fi
if [ $runStatus -ne 0 ]; then
    echo "Simulation exited with status $runStatus"
    exit 1
fi
if ! grep -q "TEST PASSED" "$logFile"; then
    echo "Simulation ended without a result"
    exit 1
fi
exit 0
